// File: include/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// bits per mesh coordinate.
`define NOC_COORD_W 3

// payload word width.
`define NOC_DATA_W 32

// entries in each input fifo.
`define NOC_FIFO_DEPTH 4

// x_plus, x_minus, y_plus, y_minus, local.
`define NOC_NUM_PORTS 5

// square mesh, routers per side.
`define NOC_MESH_SIZE 6

`endif

// File: noc_router.f
+incdir+include
verilog/noc_flit_pkg.sv
verilog/noc_route_pkg.sv
verilog/noc_input_port.sv
verilog/noc_output_arbiter.sv
verilog/noc_router.sv
verification/noc_router_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f noc_router.f --top-module noc_router_tb -o noc_router_sim \
  || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/noc_router_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verification/noc_router_tb.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_router_tb;

  localparam int NUM          = `NOC_NUM_PORTS;
  localparam int DEPTH        = `NOC_FIFO_DEPTH;
  localparam int MESH         = `NOC_MESH_SIZE;
  localparam int RESET_CYCLES = 10;
  localparam int ROUTE_N      = 30;
  localparam int RAND_N       = 40;
  localparam int FAIR_N       = 20;
  // routing, random, fairness, blocked fill and latency flits.
  localparam int TOTAL_FLITS  = NUM * (ROUTE_N + RAND_N + FAIR_N + DEPTH + 2) + NUM;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * TOTAL_FLITS;

  localparam noc_flit_pkg::coord_t ID_X = 3'd3;
  localparam noc_flit_pkg::coord_t ID_Y = 3'd3;

  logic                clk;
  logic                rst;
  logic [NUM-1:0]      in_valid;
  noc_flit_pkg::flit_t in_flit [NUM];
  logic [NUM-1:0]      out_ready;
  logic [NUM-1:0]      in_ready;
  logic [NUM-1:0]      out_valid;
  noc_flit_pkg::flit_t out_flit [NUM];

  int seed;
  int seq [NUM];
  int hold_left [NUM];
  logic fair_on;

  // indexed by output port, then input port.
  noc_flit_pkg::flit_t sb_q [NUM][NUM][$];

  logic                stalled [NUM];
  noc_flit_pkg::flit_t stall_flit [NUM];
  int                  fair_seen;
  int                  fair_last;

  noc_router i_noc_router (
    .clk       (clk      ),
    .rst       (rst      ),
    .id_x      (ID_X     ),
    .id_y      (ID_Y     ),
    .in_valid  (in_valid ),
    .in_flit   (in_flit  ),
    .out_ready (out_ready),
    .in_ready  (in_ready ),
    .out_valid (out_valid),
    .out_flit  (out_flit )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // x is decided before y and a full match ejects locally.
  function automatic noc_route_pkg::port_e expected_port(input noc_flit_pkg::flit_t f);
    if (f.dest_x != ID_X) begin
      return (f.dest_x > ID_X) ? noc_route_pkg::PORT_X_PLUS : noc_route_pkg::PORT_X_MINUS;
    end
    if (f.dest_y != ID_Y) begin
      return (f.dest_y > ID_Y) ? noc_route_pkg::PORT_Y_PLUS : noc_route_pkg::PORT_Y_MINUS;
    end
    return noc_route_pkg::PORT_LOCAL;
  endfunction

  // data holds the input port on top and a sequence number below.
  function automatic noc_flit_pkg::flit_t make_flit(input int p, input int n,
                                                    input noc_flit_pkg::coord_t dx,
                                                    input noc_flit_pkg::coord_t dy);
    noc_flit_pkg::flit_t f;
    f.dest_x = dx;
    f.dest_y = dy;
    f.src_x  = ID_X;
    f.src_y  = ID_Y;
    f.data   = {8'(p), 24'(n)};
    return f;
  endfunction

  function automatic noc_flit_pkg::coord_t rand_coord();
    return noc_flit_pkg::coord_t'($unsigned($random(seed)) % MESH);
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int o = 0; o < NUM; o++) begin
      for (int i = 0; i < NUM; i++) begin
        n += sb_q[o][i].size();
      end
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "check failed");
    end
  endtask

  task automatic compare_output(input int o);
    noc_flit_pkg::flit_t exp_flit;
    int src;
    src = int'(out_flit[o].data[31:24]);
    if (src >= NUM || sb_q[o][src].size() == 0) begin
      $display("flit %h left output %0d, but no such flit was sent there", out_flit[o], o);
      $display("Done: errors found");
      $fatal(1, "unexpected flit");
    end else begin
      exp_flit = sb_q[o][src].pop_front();
      check_value($sformatf("route_order_out%0d_in%0d", o, src), 64'(exp_flit),
                  64'(out_flit[o]));
      if (fair_on && o == int'(noc_route_pkg::PORT_LOCAL)) begin
        if (fair_seen > 0) begin
          check_value("fairness", 64'((fair_last + 1) % NUM), 64'(src));
        end
        fair_last = src;
        fair_seen++;
      end
    end
  endtask

  // samples every link on the rising edge.
  always @(posedge clk) begin
    if (rst) begin
      for (int o = 0; o < NUM; o++) begin
        stalled[o] = 1'b0;
      end
      fair_seen = 0;
    end else begin
      if (!fair_on) begin
        fair_seen = 0;
      end
      for (int i = 0; i < NUM; i++) begin
        if (in_valid[i] && in_ready[i]) begin
          sb_q[int'(expected_port(in_flit[i]))][i].push_back(in_flit[i]);
        end
      end
      for (int o = 0; o < NUM; o++) begin
        if (stalled[o]) begin
          check_value($sformatf("out_valid_held_%0d", o), 64'd1, 64'(out_valid[o]));
          check_value($sformatf("out_flit_stable_%0d", o), 64'(stall_flit[o]),
                      64'(out_flit[o]));
        end
        stalled[o]    = out_valid[o] && !out_ready[o];
        stall_flit[o] = out_flit[o];
        if (out_valid[o] && out_ready[o]) begin
          compare_output(o);
        end
      end
    end
  end

  task automatic update_ready(input bit rand_ready);
    int r;
    for (int o = 0; o < NUM; o++) begin
      if (!rand_ready) begin
        out_ready[o] = 1'b1;
      end else if (hold_left[o] > 0) begin
        out_ready[o] = 1'b0;
        hold_left[o]--;
      end else begin
        r = $random(seed) & 15;
        if (r == 0) begin
          // a long stall fills the fifos behind it.
          hold_left[o] = 20 + ($random(seed) & 15);
          out_ready[o] = 1'b0;
        end else begin
          out_ready[o] = r[0];
        end
      end
    end
  endtask

  task automatic wait_drain();
    out_ready = '1;
    @(negedge clk);
    while (pending_count() != 0 || out_valid != '0) begin
      @(negedge clk);
    end
  endtask

  // in_ready seen at a falling edge decides the transfer at the next rising edge.
  task automatic run_traffic(input int n_per_port, input bit rand_ready, input bit to_local);
    int left [NUM];
    bit taken [NUM];
    int busy;
    noc_flit_pkg::coord_t dx;
    noc_flit_pkg::coord_t dy;
    for (int p = 0; p < NUM; p++) begin
      left[p]  = n_per_port;
      taken[p] = 1'b0;
    end
    busy = 1;
    while (busy != 0) begin
      @(negedge clk);
      busy = 0;
      for (int p = 0; p < NUM; p++) begin
        if (taken[p] || !in_valid[p]) begin
          in_valid[p] = 1'b0;
          if (left[p] > 0 && (to_local || ($random(seed) & 3) != 0)) begin
            if (to_local || ($random(seed) & 7) == 0) begin
              dx = ID_X;
              dy = ID_Y;
            end else begin
              dx = rand_coord();
              dy = rand_coord();
            end
            in_flit[p]  = make_flit(p, seq[p], dx, dy);
            in_valid[p] = 1'b1;
            seq[p]++;
            left[p]--;
          end
        end
        taken[p] = in_valid[p] && in_ready[p];
        if (left[p] > 0 || (in_valid[p] && !taken[p])) begin
          busy = 1;
        end
      end
      update_ready(rand_ready);
    end
    @(negedge clk);
    in_valid = '0;
  endtask

  task automatic check_latency(input int p, input noc_flit_pkg::coord_t dx,
                               input noc_flit_pkg::coord_t dy, input int o);
    @(negedge clk);
    in_valid[p] = 1'b1;
    in_flit[p]  = make_flit(p, seq[p], dx, dy);
    seq[p]++;
    check_value("latency_in_ready", 64'd1, 64'(in_ready[p]));
    @(negedge clk);
    in_valid[p] = 1'b0;
    check_value("latency_edge1", 64'd0, 64'(out_valid[o]));
    @(negedge clk);
    check_value("latency_edge2", 64'd1, 64'(out_valid[o]));
    wait_drain();
  endtask

  // one input toward a blocked x_plus output.
  task automatic blocked_fill(input int p);
    int o;
    int accepted;
    o = int'(noc_route_pkg::PORT_X_PLUS);
    @(negedge clk);
    out_ready   = '0;
    in_valid[p] = 1'b1;
    in_flit[p]  = make_flit(p, seq[p], 3'd5, ID_Y);
    seq[p]++;
    @(negedge clk);
    in_valid[p] = 1'b0;
    // first flit parks in the output register.
    while (!out_valid[o]) begin
      @(negedge clk);
    end
    accepted    = 0;
    in_valid[p] = 1'b1;
    in_flit[p]  = make_flit(p, seq[p], 3'd4, 3'd1);
    seq[p]++;
    while (in_ready[p] && accepted < 2 * DEPTH) begin
      accepted++;
      @(negedge clk);
      in_flit[p] = make_flit(p, seq[p], 3'd5, rand_coord());
      seq[p]++;
    end
    check_value($sformatf("backpressure_depth_in%0d", p), 64'(DEPTH), 64'(accepted));
    repeat (30) begin
      @(negedge clk);
      check_value($sformatf("backpressure_in_ready_in%0d", p), 64'd0, 64'(in_ready[p]));
      check_value($sformatf("backpressure_out_valid_in%0d", p), 64'd1, 64'(out_valid[o]));
    end
    out_ready = '1;
    while (!in_ready[p]) begin
      @(negedge clk);
    end
    @(negedge clk);
    in_valid[p] = 1'b0;
    wait_drain();
  endtask

  initial begin
    seed      = 32'h2f5b_7243;
    rst       = 1'b1;
    in_valid  = '0;
    out_ready = '1;
    fair_on   = 1'b0;
    for (int p = 0; p < NUM; p++) begin
      in_flit[p]   = '0;
      seq[p]       = 0;
      hold_left[p] = 0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("reset_out_valid", 64'd0, 64'(out_valid));
    check_value("reset_in_ready", 64'((1 << NUM) - 1), 64'(in_ready));

    check_latency(0, 3'd5, 3'd3, int'(noc_route_pkg::PORT_X_PLUS));
    check_latency(1, 3'd0, 3'd3, int'(noc_route_pkg::PORT_X_MINUS));
    check_latency(2, 3'd3, 3'd5, int'(noc_route_pkg::PORT_Y_PLUS));
    check_latency(3, 3'd3, 3'd0, int'(noc_route_pkg::PORT_Y_MINUS));
    check_latency(4, 3'd3, 3'd3, int'(noc_route_pkg::PORT_LOCAL));

    run_traffic(ROUTE_N, 1'b0, 1'b0);
    wait_drain();
    for (int p = 0; p < NUM; p++) begin
      blocked_fill(p);
    end
    run_traffic(RAND_N, 1'b1, 1'b0);
    wait_drain();

    fair_on = 1'b1;
    run_traffic(FAIR_N, 1'b0, 1'b1);
    wait_drain();
    fair_on = 1'b0;

    if (pending_count() != 0) begin
      $display("%0d flits were sent but never left the router", pending_count());
      $display("Done: errors found");
      $fatal(1, "scoreboard not empty");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the outputs stalled", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

endmodule

// File: verilog/noc_flit_pkg.sv
`include "noc_macros.svh"

package noc_flit_pkg;

  // one mesh coordinate.
  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // payload word.
  typedef logic [`NOC_DATA_W-1:0] data_t;

  // single-flit packet, header fields first.
  typedef struct packed {
    coord_t dest_x;
    coord_t dest_y;
    coord_t src_x;
    coord_t src_y;
    data_t  data;
  } flit_t;

endpackage

// File: verilog/noc_input_port.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_input_port (
  input  logic                     clk,
  input  logic                     rst,
  input  noc_flit_pkg::coord_t     id_x,
  input  noc_flit_pkg::coord_t     id_y,
  input  logic                     in_valid,
  input  noc_flit_pkg::flit_t      in_flit,
  input  noc_route_pkg::port_req_t grant,
  output logic                     in_ready,
  output noc_route_pkg::port_req_t req,
  output noc_flit_pkg::flit_t      head_flit
);

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  noc_flit_pkg::flit_t  fifo_mem [DEPTH];
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W-1:0]     wr_ptr;
  logic [CNT_W-1:0]     count;
  logic                 push;
  logic                 pop;
  logic                 empty;
  noc_route_pkg::port_e route;

  // circular pointer step.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign push      = in_valid && in_ready;
  assign pop       = |(req & grant);
  assign head_flit = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // x is resolved before y.
  always_comb begin
    if (head_flit.dest_x > id_x) begin
      route = noc_route_pkg::PORT_X_PLUS;
    end else if (head_flit.dest_x < id_x) begin
      route = noc_route_pkg::PORT_X_MINUS;
    end else if (head_flit.dest_y > id_y) begin
      route = noc_route_pkg::PORT_Y_PLUS;
    end else if (head_flit.dest_y < id_y) begin
      route = noc_route_pkg::PORT_Y_MINUS;
    end else begin
      route = noc_route_pkg::PORT_LOCAL;
    end
  end

  assign req = empty ? '0 : (noc_route_pkg::port_req_t'(1) << route);

  // the sender never gets a slot the fifo does not have.
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> !((wr_ptr == rd_ptr) && !empty));

  // a grant only lands on the request of a live head.
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    (grant != '0) |-> (grant == req));

  a_req_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(req));

endmodule

// File: verilog/noc_output_arbiter.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_output_arbiter (
  input  logic                     clk,
  input  logic                     rst,
  input  noc_route_pkg::port_req_t req,
  input  noc_flit_pkg::flit_t      head_flits [`NOC_NUM_PORTS],
  input  logic                     out_ready,
  output noc_route_pkg::port_req_t grant,
  output logic                     out_valid,
  output noc_flit_pkg::flit_t      out_flit
);

  localparam int NUM   = `NOC_NUM_PORTS;
  localparam int IDX_W = $clog2(NUM);

  noc_route_pkg::arb_state_e state;
  logic [IDX_W-1:0]          prio_ptr;
  logic [IDX_W-1:0]          win_idx;
  logic [IDX_W:0]            scan_sum;
  logic                      found;
  logic                      can_load;

  // register is free, or its flit leaves this cycle.
  assign can_load  = (state == noc_route_pkg::ARB_IDLE) || out_ready;
  assign out_valid = (state == noc_route_pkg::ARB_HOLD);

  // first requester at or after the pointer, wrapping at NUM.
  always_comb begin
    found    = 1'b0;
    win_idx  = prio_ptr;
    scan_sum = '0;
    for (int i = 0; i < NUM; i++) begin
      scan_sum = {1'b0, prio_ptr} + (IDX_W + 1)'(i);
      if (scan_sum >= (IDX_W + 1)'(NUM)) begin
        scan_sum = scan_sum - (IDX_W + 1)'(NUM);
      end
      if (!found && req[scan_sum[IDX_W-1:0]]) begin
        found   = 1'b1;
        win_idx = scan_sum[IDX_W-1:0];
      end
    end
  end

  always_comb begin
    grant = '0;
    if (can_load && found) begin
      grant[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= noc_route_pkg::ARB_IDLE;
      prio_ptr <= IDX_W'(noc_route_pkg::PORT_X_PLUS);
    end else begin
      if (grant != '0) begin
        state <= noc_route_pkg::ARB_HOLD;
        // winner drops to lowest priority.
        prio_ptr <= (win_idx == IDX_W'(NUM - 1)) ? '0 : win_idx + 1'b1;
      end else if (out_ready) begin
        state <= noc_route_pkg::ARB_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant != '0) begin
      out_flit <= head_flits[win_idx];
    end
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~req) == '0));

  // link rule, a stalled flit stays put until taken.
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_flit)));

endmodule

// File: verilog/noc_route_pkg.sv
`include "noc_macros.svh"

package noc_route_pkg;

  localparam int PORT_W = $clog2(`NOC_NUM_PORTS);

  // port index, also the index of every per-port array.
  typedef enum logic [PORT_W-1:0] {
    PORT_X_PLUS  = 3'd0,
    PORT_X_MINUS = 3'd1,
    PORT_Y_PLUS  = 3'd2,
    PORT_Y_MINUS = 3'd3,
    PORT_LOCAL   = 3'd4
  } port_e;

  // one bit per port_e value.
  typedef logic [`NOC_NUM_PORTS-1:0] port_req_t;

  // output stage, empty or holding a flit.
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_HOLD = 1'b1
  } arb_state_e;

endpackage

// File: verilog/noc_router.sv
`timescale 1ns/1ps
`include "noc_macros.svh"

module noc_router (
  input  logic                       clk,
  input  logic                       rst,
  input  noc_flit_pkg::coord_t       id_x,
  input  noc_flit_pkg::coord_t       id_y,
  input  logic [`NOC_NUM_PORTS-1:0]  in_valid,
  input  noc_flit_pkg::flit_t        in_flit [`NOC_NUM_PORTS],
  input  logic [`NOC_NUM_PORTS-1:0]  out_ready,
  output logic [`NOC_NUM_PORTS-1:0]  in_ready,
  output logic [`NOC_NUM_PORTS-1:0]  out_valid,
  output noc_flit_pkg::flit_t        out_flit [`NOC_NUM_PORTS]
);

  localparam int NUM = `NOC_NUM_PORTS;

  // rows indexed by input port, columns by output port.
  noc_route_pkg::port_req_t req_from_port  [NUM];
  noc_route_pkg::port_req_t grant_to_port  [NUM];
  // rows indexed by output port, columns by input port.
  noc_route_pkg::port_req_t req_to_arb     [NUM];
  noc_route_pkg::port_req_t grant_from_arb [NUM];
  noc_flit_pkg::flit_t      port_head      [NUM];

  always_comb begin
    for (int o = 0; o < NUM; o++) begin
      for (int i = 0; i < NUM; i++) begin
        req_to_arb[o][i] = req_from_port[i][o];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM; i++) begin
      for (int o = 0; o < NUM; o++) begin
        grant_to_port[i][o] = grant_from_arb[o][i];
      end
    end
  end

  for (genvar p = 0; p < NUM; p++) begin : g_in
    noc_input_port i_input_port (
      .clk       (clk             ),
      .rst       (rst             ),
      .id_x      (id_x            ),
      .id_y      (id_y            ),
      .in_valid  (in_valid[p]     ),
      .in_flit   (in_flit[p]      ),
      .grant     (grant_to_port[p]),
      .in_ready  (in_ready[p]     ),
      .req       (req_from_port[p]),
      .head_flit (port_head[p]    )
    );
  end

  for (genvar p = 0; p < NUM; p++) begin : g_out
    noc_output_arbiter i_output_arbiter (
      .clk        (clk              ),
      .rst        (rst              ),
      .req        (req_to_arb[p]    ),
      .head_flits (port_head        ),
      .out_ready  (out_ready[p]     ),
      .grant      (grant_from_arb[p]),
      .out_valid  (out_valid[p]     ),
      .out_flit   (out_flit[p]      )
    );
  end

  // end to end route check on the ejection port.
  a_local_dest: assert property (@(posedge clk) disable iff (rst)
    out_valid[noc_route_pkg::PORT_LOCAL] |->
      (out_flit[noc_route_pkg::PORT_LOCAL].dest_x == id_x) &&
      (out_flit[noc_route_pkg::PORT_LOCAL].dest_y == id_y));

  // x is resolved first, so x_plus only carries eastbound flits.
  a_x_plus_dest: assert property (@(posedge clk) disable iff (rst)
    out_valid[noc_route_pkg::PORT_X_PLUS] |->
      (out_flit[noc_route_pkg::PORT_X_PLUS].dest_x > id_x));

endmodule
